// File: common/logcmp_isa_pkg.sv
// Logic and compare ISA package: operation encodings, function select and execute parameters
`default_nettype none

package logcmp_isa_pkg;

	// The ten operations carried by a buffer entry
	typedef enum logic [3:0] {
		OP_SLTI  = 4'd0,
		OP_SLTIU = 4'd1,
		OP_SLT   = 4'd2,
		OP_SLTU  = 4'd3,
		OP_XORI  = 4'd4,
		OP_ORI   = 4'd5,
		OP_ANDI  = 4'd6,
		OP_XOR   = 4'd7,
		OP_OR    = 4'd8,
		OP_AND   = 4'd9
	} logcmp_op_e;

	// One-hot function select for the execute stage
	typedef struct packed {
		logic fun_slt;
		logic fun_xor;
		logic fun_or;
		logic fun_and;
	} logcmp_fun_t;

	localparam int EXE_TAG_W = 7; // Matches the physical tag width of the core
	localparam int EXE_DW = 64;

	// Registered output of the issue stage
	typedef struct packed {
		logcmp_fun_t fun;
		logic [EXE_TAG_W-1:0] rd0;
		logic [EXE_DW-1:0] op1;
		logic [EXE_DW-1:0] op2;
		logic is_usi; // Unsigned compare for sltiu and sltu
	} logcmp_exeparam_t;

endpackage

`default_nettype wire

// File: common/logcmp_core_pkg.sv
// Core package: register and tag sizes, entry layout and writeback bundle
`default_nettype none

package logcmp_core_pkg;

	localparam int XLEN = 64;
	localparam int RB = 2; // Rename copies per architectural register
	localparam int ARCH_W = 5;
	localparam int TAG_W = ARCH_W + RB;
	localparam int PHY_NUM = 2 ** TAG_W;

	// Architectural number on top, rename copy below
	typedef struct packed {
		logic [ARCH_W-1:0] arch;
		logic [RB-1:0] copy;
	} phy_tag_t;

	typedef struct packed {
		logic [XLEN-TAG_W-1:0] pad;
		phy_tag_t rs2;
	} logcmp_src2_reg_t;

	// Second source word: immediate for the i forms, rs2 tag for the register forms
	typedef union packed {
		logic [XLEN-1:0] imm;
		logcmp_src2_reg_t reg_view;
	} logcmp_src2_u;

	typedef struct packed {
		logcmp_isa_pkg::logcmp_op_e op;
		phy_tag_t rd0;
		phy_tag_t rs1;
		logcmp_src2_u src2;
	} logcmp_entry_t;

	typedef struct packed {
		logic valid;
		phy_tag_t rd;
		logic [XLEN-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

// File: hw/logcmp_issue/lzp.sv
// Lowest zero finder, flags the case where every bit is one
`timescale 1ns/1ns
`default_nettype none

module lzp #(
	parameter int CW = 3
) (
	input wire logic [2**CW-1:0] in_i,
	output logic [CW-1:0] pos_o,
	output logic all1
);

	localparam int W = 2 ** CW;

	always_comb begin
		pos_o = '0;
		all1 = 1'b1;
		// Scan downward so the lowest zero is the last one kept
		for (int i = W - 1; i >= 0; i--) begin
			if (!in_i[i]) begin
				pos_o = CW'(i);
				all1 = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/logcmp_buffer.sv
// Logic and compare issue buffer, fills the lowest free slot and frees popped slots
`timescale 1ns/1ns
`default_nettype none

module logcmp_buffer #(
	parameter int DP = 8
) (
	input wire logic CLK,
	input wire logic arst_n,

	input wire logic disp_valid,
	input wire logcmp_core_pkg::logcmp_entry_t disp_entry,

	input wire logic pop,
	input wire logic [$clog2(DP)-1:0] pop_index,

	output logic [DP-1:0] malloc,
	output logcmp_core_pkg::logcmp_entry_t entries [DP],
	output logic buffer_full
);

	localparam int IW = $clog2(DP);

	logic [DP-1:0] pop_mask;
	logic [DP-1:0] free_vec;
	logic [IW-1:0] free_idx;

	// A slot being popped this cycle counts as free
	assign pop_mask = pop ? (DP'(1) << pop_index) : '0;
	assign free_vec = ~malloc | pop_mask;

	always_comb begin
		free_idx = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (free_vec[i]) begin
				free_idx = IW'(i);
			end
		end
	end

	assign buffer_full = &malloc;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			malloc <= '0;
		end else begin
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (disp_valid) begin
				malloc[free_idx] <= 1'b1; // Refill of the popped slot wins
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (disp_valid) begin
			entries[free_idx] <= disp_entry;
		end
	end

endmodule

`default_nettype wire

// File: hw/logcmp_issue/logcmp_issue.sv
// Logic and compare issue stage, picks the lowest ready entry and registers its execute parameters
`timescale 1ns/1ns
`default_nettype none

module logcmp_issue #(
	parameter int DP = 8
) (
	input wire logic CLK,
	input wire logic arst_n,

	input wire logic [DP-1:0] malloc,
	input wire logcmp_core_pkg::logcmp_entry_t entries [DP],
	input wire logic [logcmp_core_pkg::PHY_NUM-1:0] wb_log,

	output logcmp_core_pkg::phy_tag_t rs1_tag [DP],
	output logcmp_core_pkg::phy_tag_t rs2_tag [DP],
	input wire logic [logcmp_core_pkg::XLEN-1:0] src1 [DP],
	input wire logic [logcmp_core_pkg::XLEN-1:0] src2 [DP],

	output logic pop,
	output logic [$clog2(DP)-1:0] pop_index,
	output logcmp_isa_pkg::logcmp_exeparam_t exeparam,
	output logic exeparam_valid
);

	logic [DP-1:0] slot_ready;
	logcmp_isa_pkg::logcmp_exeparam_t slot_param [DP];
	logic none_ready;

	for (genvar i = 0; i < DP; i++) begin : g_slot
		logcmp_isa_pkg::logcmp_op_e op;
		logic is_imm;
		logic rs1_rdy;
		logic rs2_rdy;
		logcmp_isa_pkg::logcmp_fun_t fun;
		logic is_usi;

		assign op = entries[i].op;
		assign is_imm = op inside {logcmp_isa_pkg::OP_SLTI, logcmp_isa_pkg::OP_SLTIU,
			logcmp_isa_pkg::OP_XORI, logcmp_isa_pkg::OP_ORI, logcmp_isa_pkg::OP_ANDI};

		assign fun.fun_slt = op inside {logcmp_isa_pkg::OP_SLTI, logcmp_isa_pkg::OP_SLTIU,
			logcmp_isa_pkg::OP_SLT, logcmp_isa_pkg::OP_SLTU};
		assign fun.fun_xor = op inside {logcmp_isa_pkg::OP_XORI, logcmp_isa_pkg::OP_XOR};
		assign fun.fun_or = op inside {logcmp_isa_pkg::OP_ORI, logcmp_isa_pkg::OP_OR};
		assign fun.fun_and = op inside {logcmp_isa_pkg::OP_ANDI, logcmp_isa_pkg::OP_AND};
		assign is_usi = op inside {logcmp_isa_pkg::OP_SLTIU, logcmp_isa_pkg::OP_SLTU};

		// The rs2 view is only meaningful for the register forms
		assign rs1_tag[i] = entries[i].rs1;
		assign rs2_tag[i] = entries[i].src2.reg_view.rs2;

		// Register 0 never waits on a writeback
		assign rs1_rdy = wb_log[rs1_tag[i]] | (rs1_tag[i].arch == '0);
		assign rs2_rdy = wb_log[rs2_tag[i]] | (rs2_tag[i].arch == '0);

		assign slot_ready[i] = malloc[i] & rs1_rdy & (is_imm | rs2_rdy);

		assign slot_param[i] = '{
			fun: fun,
			rd0: entries[i].rd0,
			op1: src1[i],
			op2: is_imm ? entries[i].src2.imm : src2[i],
			is_usi: is_usi
		};
	end

	lzp #(
		.CW($clog2(DP))
	) u_pick (
		.in_i(~slot_ready),
		.pos_o(pop_index),
		.all1(none_ready)
	);

	// Execute is always ready, so anything picked leaves the buffer
	assign pop = ~none_ready;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		exeparam <= slot_param[pop_index];
	end

endmodule

`default_nettype wire

// File: hw/logcmp_execute.sv
// Logic and compare execute unit, computes the result and registers the writeback
`timescale 1ns/1ns
`default_nettype none

module logcmp_execute (
	input wire logic CLK,
	input wire logic arst_n,

	input wire logcmp_isa_pkg::logcmp_exeparam_t exeparam,
	input wire logic exeparam_valid,

	output logcmp_core_pkg::wb_t wb
);

	logic less_than;
	logic [logcmp_core_pkg::XLEN-1:0] result;

	logic wb_valid_q;
	logcmp_core_pkg::phy_tag_t wb_rd_q;
	logic [logcmp_core_pkg::XLEN-1:0] wb_data_q;

	assign less_than = exeparam.is_usi ? (exeparam.op1 < exeparam.op2)
		: ($signed(exeparam.op1) < $signed(exeparam.op2));

	always_comb begin
		result = '0;
		if (exeparam.fun.fun_slt) begin
			result = {{(logcmp_core_pkg::XLEN-1){1'b0}}, less_than};
		end else if (exeparam.fun.fun_xor) begin
			result = exeparam.op1 ^ exeparam.op2;
		end else if (exeparam.fun.fun_or) begin
			result = exeparam.op1 | exeparam.op2;
		end else if (exeparam.fun.fun_and) begin
			result = exeparam.op1 & exeparam.op2;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= exeparam_valid;
		end
	end

	always_ff @(posedge CLK) begin
		wb_rd_q <= exeparam.rd0;
		wb_data_q <= result;
	end

	assign wb.valid = wb_valid_q;
	assign wb.rd = wb_rd_q;
	assign wb.data = wb_data_q;

endmodule

`default_nettype wire

// File: hw/phy_regfile.sv
// Physical register file with per-slot read ports and the writeback ready log
`timescale 1ns/1ns
`default_nettype none

module phy_regfile #(
	parameter int DP = 8
) (
	input wire logic CLK,
	input wire logic arst_n,

	input wire logic disp_valid,
	input wire logcmp_core_pkg::phy_tag_t disp_rd,
	input wire logcmp_core_pkg::wb_t wb,

	input wire logcmp_core_pkg::phy_tag_t rs1_tag [DP],
	input wire logcmp_core_pkg::phy_tag_t rs2_tag [DP],
	output logic [logcmp_core_pkg::XLEN-1:0] src1 [DP],
	output logic [logcmp_core_pkg::XLEN-1:0] src2 [DP],
	output logic [logcmp_core_pkg::PHY_NUM-1:0] wb_log
);

	logic [logcmp_core_pkg::XLEN-1:0] regs [logcmp_core_pkg::PHY_NUM];
	logic wb_write;

	assign wb_write = wb.valid & (wb.rd.arch != '0); // Writes to x0 are dropped

	always_ff @(posedge CLK) begin
		if (wb_write) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_log <= '1;
		end else begin
			if (wb_write) begin
				wb_log[wb.rd] <= 1'b1;
			end
			if (disp_valid && disp_rd.arch != '0) begin
				wb_log[disp_rd] <= 1'b0;
			end
		end
	end

	for (genvar i = 0; i < DP; i++) begin : g_read
		assign src1[i] = (rs1_tag[i].arch == '0) ? '0 : regs[rs1_tag[i]];
		assign src2[i] = (rs2_tag[i].arch == '0) ? '0 : regs[rs2_tag[i]];
	end

endmodule

`default_nettype wire

// File: hw/logcmp_unit.sv
// Logic and compare unit top level: buffer, issue, execute and register file
`timescale 1ns/1ns
`default_nettype none

module logcmp_unit #(
	parameter int DP = 8
) (
	input wire logic CLK,
	input wire logic arst_n,

	input wire logic disp_valid,
	input wire logcmp_core_pkg::logcmp_entry_t disp_entry,
	output logic buffer_full,

	output logcmp_core_pkg::wb_t wb
);

	logic [DP-1:0] malloc;
	logcmp_core_pkg::logcmp_entry_t entries [DP];
	logic pop;
	logic [$clog2(DP)-1:0] pop_index;

	logcmp_core_pkg::phy_tag_t rs1_tag [DP];
	logcmp_core_pkg::phy_tag_t rs2_tag [DP];
	logic [logcmp_core_pkg::XLEN-1:0] src1 [DP];
	logic [logcmp_core_pkg::XLEN-1:0] src2 [DP];
	logic [logcmp_core_pkg::PHY_NUM-1:0] wb_log;

	logcmp_isa_pkg::logcmp_exeparam_t exeparam;
	logic exeparam_valid;

	logcmp_buffer #(
		.DP(DP)
	) u_buffer (
		.CLK(CLK),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.disp_entry(disp_entry),
		.pop(pop),
		.pop_index(pop_index),
		.malloc(malloc),
		.entries(entries),
		.buffer_full(buffer_full)
	);

	logcmp_issue #(
		.DP(DP)
	) u_issue (
		.CLK(CLK),
		.arst_n(arst_n),
		.malloc(malloc),
		.entries(entries),
		.wb_log(wb_log),
		.rs1_tag(rs1_tag),
		.rs2_tag(rs2_tag),
		.src1(src1),
		.src2(src2),
		.pop(pop),
		.pop_index(pop_index),
		.exeparam(exeparam),
		.exeparam_valid(exeparam_valid)
	);

	logcmp_execute u_execute (
		.CLK(CLK),
		.arst_n(arst_n),
		.exeparam(exeparam),
		.exeparam_valid(exeparam_valid),
		.wb(wb)
	);

	phy_regfile #(
		.DP(DP)
	) u_regfile (
		.CLK(CLK),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.disp_rd(disp_entry.rd0), // Destination turns not ready on dispatch
		.wb(wb),
		.rs1_tag(rs1_tag),
		.rs2_tag(rs2_tag),
		.src1(src1),
		.src2(src2),
		.wb_log(wb_log)
	);

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// Testbench clock generator, free running with a fixed period
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever begin
			#(PERIOD / 2) CLK = ~CLK;
		end
	end

endmodule

`default_nettype wire

// File: dv/logcmp_assertions.sv
// Concurrent checks on the logic and compare unit, bound to its top level
`timescale 1ns/1ns
`default_nettype none

module logcmp_assertions (
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic disp_valid,
	input wire logcmp_core_pkg::logcmp_entry_t disp_entry,
	input wire logic buffer_full,
	input wire logic exeparam_valid,
	input wire logcmp_core_pkg::wb_t wb
);

	logic [logcmp_core_pkg::PHY_NUM-1:0] pending_q;
	int fail_count = 0;

	// Tags with a dispatched op that has not written back yet
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pending_q <= '0;
		end else begin
			if (wb.valid) begin
				pending_q[wb.rd] <= 1'b0;
			end
			if (disp_valid) begin
				pending_q[disp_entry.rd0] <= 1'b1;
			end
		end
	end

	a_no_disp_when_full: assert property (@(posedge CLK) disable iff (!arst_n)
		disp_valid |-> !buffer_full)
		else begin
			$error("dispatch while the buffer is full");
			fail_count++;
		end

	a_wb_after_issue: assert property (@(posedge CLK) disable iff (!arst_n)
		wb.valid |-> $past(exeparam_valid))
		else begin
			$error("writeback without an issued op one cycle earlier");
			fail_count++;
		end

	a_wb_pending: assert property (@(posedge CLK) disable iff (!arst_n)
		wb.valid |-> pending_q[wb.rd])
		else begin
			$error("writeback to a tag with no outstanding op");
			fail_count++;
		end

	a_empty_after_reset: assert property (@(posedge CLK) $rose(arst_n) |-> !buffer_full)
		else begin
			$error("buffer full right after reset");
			fail_count++;
		end

endmodule

bind logcmp_unit logcmp_assertions u_checks (
	.CLK(CLK),
	.arst_n(arst_n),
	.disp_valid(disp_valid),
	.disp_entry(disp_entry),
	.buffer_full(buffer_full),
	.exeparam_valid(exeparam_valid),
	.wb(wb)
);

`default_nettype wire

// File: dv/logcmp_tb.sv
// Testbench for the logic and compare unit that runs random dependent programs against a model
`timescale 1ns/1ns
`default_nettype none

module logcmp_tb;

	localparam int DP = 8;
	localparam int NTAG = logcmp_core_pkg::PHY_NUM;
	localparam int TIMEOUT = 200;

	logic CLK;
	logic arst_n;
	logic disp_valid;
	logcmp_core_pkg::logcmp_entry_t disp_entry;
	logic buffer_full;
	logcmp_core_pkg::wb_t wb;

	// Model state indexed by physical tag
	logic [63:0] model_val [NTAG];
	logic [63:0] exp_val [NTAG];
	bit pending [NTAG];
	int ref_cnt [NTAG];
	logcmp_core_pkg::phy_tag_t src_a [NTAG];
	logcmp_core_pkg::phy_tag_t src_b [NTAG];
	bit has_b [NTAG];
	int disp_edge [NTAG];

	int cyc = 0;
	int outstanding = 0;
	bit full_q = 1'b0;
	bit seen_full = 1'b0;
	bit abort = 1'b0;
	logcmp_core_pkg::phy_tag_t last_rd = '0;
	int wb_errors = 0;
	int lat_errors = 0;
	int idle_errors = 0;
	int drain_errors = 0;
	int full_errors = 0;
	int timeouts = 0;
	int assert_errors = 0;

	tb_clock #(
		.PERIOD(8)
	) u_clock (
		.CLK(CLK)
	);

	logcmp_unit #(
		.DP(DP)
	) dut0 (
		.CLK(CLK),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.disp_entry(disp_entry),
		.buffer_full(buffer_full),
		.wb(wb)
	);

	function automatic logic [63:0] sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	function automatic bit imm_form(input logcmp_isa_pkg::logcmp_op_e op);
		return op inside {logcmp_isa_pkg::OP_SLTI, logcmp_isa_pkg::OP_SLTIU,
			logcmp_isa_pkg::OP_XORI, logcmp_isa_pkg::OP_ORI, logcmp_isa_pkg::OP_ANDI};
	endfunction

	function automatic logic [63:0] read_model(input logcmp_core_pkg::phy_tag_t t);
		return (t.arch == '0) ? 64'd0 : model_val[t]; // x0 always reads as zero
	endfunction

	function automatic logic [63:0] expect_result(input logcmp_isa_pkg::logcmp_op_e op,
		input logic [63:0] a, input logic [63:0] b);
		case (op)
			logcmp_isa_pkg::OP_SLTI, logcmp_isa_pkg::OP_SLT:
				return {63'd0, $signed(a) < $signed(b)};
			logcmp_isa_pkg::OP_SLTIU, logcmp_isa_pkg::OP_SLTU:
				return {63'd0, a < b};
			logcmp_isa_pkg::OP_XORI, logcmp_isa_pkg::OP_XOR:
				return a ^ b;
			logcmp_isa_pkg::OP_ORI, logcmp_isa_pkg::OP_OR:
				return a | b;
			default:
				return a & b;
		endcase
	endfunction

	// Half of the sources point at a tag still waiting for its producer
	function automatic logcmp_core_pkg::phy_tag_t pick_source();
		logcmp_core_pkg::phy_tag_t busy [$];
		logcmp_core_pkg::phy_tag_t t;
		int unsigned r;
		r = $urandom_range(0, 7);
		for (int i = 0; i < NTAG; i++) begin
			if (pending[i]) begin
				busy.push_back(7'(i));
			end
		end
		t = 7'($urandom_range(0, NTAG - 1));
		if (r == 0) begin
			t.arch = '0;
		end else if (r < 5 && busy.size() > 0) begin
			t = busy[$urandom_range(0, busy.size() - 1)];
		end
		return t;
	endfunction

	task automatic pick_dest(input logcmp_core_pkg::phy_tag_t rs1,
		input logcmp_core_pkg::phy_tag_t rs2, input bit imm,
		output logcmp_core_pkg::phy_tag_t rd, output bit ok);
		ok = 1'b0;
		rd = '0;
		for (int n = 0; n < 64 && !ok; n++) begin
			rd = 7'($urandom_range(0, NTAG - 1));
			if ($urandom_range(0, 15) == 0) begin
				rd.arch = '0;
			end
			ok = !pending[rd] && ref_cnt[rd] == 0 && rd != rs1 && (imm || rd != rs2);
		end
	endtask

	task automatic make_entry(input logcmp_isa_pkg::logcmp_op_e op, input bit chained,
		output logcmp_core_pkg::logcmp_entry_t e, output bit ok);
		logcmp_core_pkg::phy_tag_t rd;
		e = '0;
		e.op = op;
		e.rs1 = chained ? last_rd : pick_source();
		if (imm_form(op)) begin
			e.src2.imm = sext12(12'($urandom));
		end else begin
			e.src2.reg_view.pad = 57'({$urandom, $urandom});
			e.src2.reg_view.rs2 = pick_source();
		end
		pick_dest(e.rs1, e.src2.reg_view.rs2, imm_form(op), rd, ok);
		e.rd0 = rd;
	endtask

	// At most one dispatch every other cycle so a low full flag guarantees a slot
	task automatic dispatch_entry(input logcmp_core_pkg::logcmp_entry_t e);
		logic [63:0] a;
		logic [63:0] b;
		bit imm;
		bit granted;
		imm = imm_form(e.op);
		granted = 1'b0;
		for (int n = 0; n < TIMEOUT && !granted; n++) begin
			@(posedge CLK);
			disp_valid <= 1'b0;
			granted = !full_q && !disp_valid;
		end
		if (!granted) begin
			$display("Timeout: the buffer never freed a slot for dispatch");
			timeouts++;
			abort = 1'b1;
		end else begin
			a = read_model(e.rs1);
			b = imm ? e.src2.imm : read_model(e.src2.reg_view.rs2);
			disp_valid <= 1'b1;
			disp_entry <= e;
			exp_val[e.rd0] = expect_result(e.op, a, b);
			if (e.rd0.arch != '0) begin
				model_val[e.rd0] = exp_val[e.rd0];
			end
			pending[e.rd0] = 1'b1;
			src_a[e.rd0] = e.rs1;
			src_b[e.rd0] = e.src2.reg_view.rs2;
			has_b[e.rd0] = !imm;
			ref_cnt[e.rs1]++;
			if (!imm) begin
				ref_cnt[e.src2.reg_view.rs2]++;
			end
			outstanding++;
			last_rd = e.rd0;
		end
	endtask

	task automatic check_wb(input logcmp_core_pkg::wb_t w);
		if (!pending[w.rd]) begin
			$display("[ERROR] %0t writeback to tag %0d with no outstanding op", $time,
				int'(w.rd));
			wb_errors++;
		end else if (w.data !== exp_val[w.rd]) begin
			$display("[ERROR] %0t tag %0d data %h, expected %h", $time, int'(w.rd), w.data,
				exp_val[w.rd]);
			wb_errors++;
		end
	endtask

	task automatic check_latency(input logcmp_core_pkg::phy_tag_t rd, input int lat);
		if (lat < 3) begin
			$display("[ERROR] %0t tag %0d wrote back %0d cycles after dispatch", $time,
				int'(rd), lat);
			lat_errors++;
		end
	endtask

	task automatic check_idle(input logcmp_core_pkg::wb_t w, input logic full);
		if (w.valid || full) begin
			$display("[ERROR] %0t wb.valid %b buffer_full %b before any dispatch", $time,
				w.valid, full);
			idle_errors++;
		end
	endtask

	task automatic check_full(input bit seen);
		if (!seen) begin
			$display("[ERROR] %0t buffer_full never rose during the dependent chain", $time);
			full_errors++;
		end
	endtask

	task automatic check_drain(input int left);
		if (left != 0) begin
			for (int t = 0; t < NTAG; t++) begin
				if (pending[t]) begin
					$display("[ERROR] %0t op writing tag %0d never wrote back", $time, t);
					drain_errors++;
				end
			end
		end
	endtask

	task automatic retire(input logcmp_core_pkg::wb_t w);
		check_wb(w);
		check_latency(w.rd, cyc - disp_edge[w.rd] + 1);
		if (pending[w.rd]) begin
			pending[w.rd] = 1'b0;
			ref_cnt[src_a[w.rd]]--;
			if (has_b[w.rd]) begin
				ref_cnt[src_b[w.rd]]--;
			end
			outstanding--;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(posedge CLK);
		disp_valid <= 1'b0;
		while (outstanding > 0 && n < 4 * TIMEOUT) begin
			@(posedge CLK);
			n++;
		end
		if (outstanding > 0) begin
			$display("Timeout: %0d ops still outstanding after the drain limit", outstanding);
			timeouts++;
		end
		check_drain(outstanding);
	endtask

	always @(posedge CLK) begin
		cyc <= cyc + 1;
	end

	// Outputs are sampled at the falling edge halfway between drive edges
	always @(negedge CLK) begin
		if (arst_n) begin
			full_q = buffer_full;
			if (buffer_full) begin
				seen_full = 1'b1;
			end
			if (disp_valid) begin
				disp_edge[disp_entry.rd0] = cyc + 1;
			end
			if (wb.valid) begin
				retire(wb);
			end
		end
	end

	initial begin
		logcmp_core_pkg::logcmp_entry_t e;
		bit ok;
		void'($urandom(32'he1ba));
		arst_n = 1'b0;
		disp_valid = 1'b0;
		disp_entry = '0;
		repeat (4) @(posedge CLK);
		arst_n <= 1'b1;
		repeat (4) begin
			@(negedge CLK);
			check_idle(wb, buffer_full);
		end

		// Give every non-zero tag a known value through ori from x0
		for (int t = 4; t < NTAG && !abort; t++) begin
			e = '0;
			e.op = logcmp_isa_pkg::OP_ORI;
			e.rd0 = 7'(t);
			e.src2.imm = sext12(12'($urandom));
			dispatch_entry(e);
		end
		wait_drain();

		for (int i = 0; i < 400 && !abort; i++) begin
			make_entry(logcmp_isa_pkg::logcmp_op_e'(4'($urandom_range(0, 9))), 1'b0, e, ok);
			if (ok) begin
				dispatch_entry(e);
			end
		end
		wait_drain();

		// Each op waits on the one before it so the buffer backs up
		seen_full = 1'b0;
		for (int i = 0; i < 60 && !abort; i++) begin
			make_entry(logcmp_isa_pkg::logcmp_op_e'(4'($urandom_range(0, 9))), 1'b1, e, ok);
			if (ok) begin
				dispatch_entry(e);
			end
		end
		wait_drain();
		check_full(seen_full);

		assert_errors = dut0.u_checks.fail_count;
		$display("Errors: wb %0d lat %0d idle %0d full %0d drain %0d assert %0d timeout %0d",
			wb_errors, lat_errors, idle_errors, full_errors, drain_errors, assert_errors,
			timeouts);
		if (wb_errors + lat_errors + idle_errors + full_errors + drain_errors
			+ assert_errors + timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logcmp_unit.f
common/logcmp_isa_pkg.sv
common/logcmp_core_pkg.sv
hw/logcmp_issue/lzp.sv
hw/logcmp_buffer.sv
hw/logcmp_issue/logcmp_issue.sv
hw/logcmp_execute.sv
hw/phy_regfile.sv
hw/logcmp_unit.sv
dv/tb_clock.sv
dv/logcmp_assertions.sv
dv/logcmp_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = logcmp_tb
FILELIST   = logcmp_unit.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
RUN_ARGS   = +verilator+error+limit+100
BUILD      = obj_dir
LOG        = sim.log
FAIL_MSG   = test failed
PASS_MSG   = test passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)
